//--- hdl/mips_pkg.sv
package mips_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_num_t;

    localparam logic [xlen-1:0] nop_inst = '0;
    localparam logic [xlen-1:0] reset_pc = '0;

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'b000000;
    localparam logic [5:0] op_addiu = 6'b001001;
    localparam logic [5:0] op_addi  = 6'b001000;
    localparam logic [5:0] op_andi  = 6'b001100;
    localparam logic [5:0] op_ori   = 6'b001101;
    localparam logic [5:0] op_xori  = 6'b001110;
    localparam logic [5:0] op_slti  = 6'b001010;
    localparam logic [5:0] op_lui   = 6'b001111;
    localparam logic [5:0] op_lw    = 6'b100011;
    localparam logic [5:0] op_sw    = 6'b101011;

    // funct field of r-type words
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_add  = 6'b100000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_sub  = 6'b100010;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src;    // immediate as operand b
        logic    shift_src;  // shamt as operand a
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [xlen-1:0] rs_data;
        logic [xlen-1:0] rt_data;
        logic [xlen-1:0] immediate;
        logic [xlen-1:0] shift_amount;
        reg_num_t        rd_num;
    } id_ex_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] rt_data;
        reg_num_t        rd_num;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_write;
        reg_num_t        rd_num;
        logic [xlen-1:0] data;
    } mem_wb_t;

endpackage

//--- hdl/stage_link.sv
`timescale 1ns/1ns

// one pipeline register boundary, payload type set per instance
interface stage_link #(
    parameter type payload_t = logic
);
    logic     valid;
    payload_t payload;
    logic     hold;    // back-pressure from the consumer

    modport source (
        output valid,
        output payload,
        input  hold
    );

    modport sink (
        input  valid,
        input  payload,
        output hold
    );
endinterface

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            hold,
    input  logic [xlen-1:0] inst,
    output logic [xlen-1:0] inst_addr,
    output logic [xlen-1:0] id_inst,
    output logic            id_valid
);
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_next;

    assign pc_next   = pc + 32'd4;
    assign inst_addr = pc;   // same address is shown again while held

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            id_valid <= 1'b0;
        end else if (!hold) begin
            pc       <= pc_next;
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            id_inst <= inst;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] id_inst,
    input  logic            id_valid,
    input  logic [xlen-1:0] rs_data,
    input  logic [xlen-1:0] rt_data,
    output reg_num_t        rs_num,
    output reg_num_t        rt_num,
    stage_link.source       to_ex
);
    logic [5:0] opcode;
    logic [5:0] funct;
    ctrl_t      ctrl;
    logic       legal;
    logic       zero_ext;
    id_ex_t     id_ex_next;

    assign opcode = id_inst[31:26];
    assign funct  = id_inst[5:0];
    assign rs_num = id_inst[25:21];
    assign rt_num = id_inst[20:16];

    always_comb begin
        ctrl           = '0;
        legal          = 1'b1;
        zero_ext       = 1'b0;
        ctrl.reg_write = 1'b1;
        case (opcode)
            op_rtype: begin
                case (funct)
                    fn_addu, fn_add: ctrl.alu_op = alu_add;   // add runs without overflow trap
                    fn_subu, fn_sub: ctrl.alu_op = alu_sub;
                    fn_and:          ctrl.alu_op = alu_and;
                    fn_or:           ctrl.alu_op = alu_or;
                    fn_xor:          ctrl.alu_op = alu_xor;
                    fn_nor:          ctrl.alu_op = alu_nor;
                    fn_slt:          ctrl.alu_op = alu_slt;
                    fn_sll:          ctrl.alu_op = alu_sll;
                    fn_srl:          ctrl.alu_op = alu_srl;
                    fn_sra:          ctrl.alu_op = alu_sra;
                    default:         legal = 1'b0;
                endcase
            end
            op_addiu, op_addi: ctrl.alu_op = alu_add;
            op_slti:           ctrl.alu_op = alu_slt;
            op_andi: begin
                ctrl.alu_op = alu_and;
                zero_ext    = 1'b1;
            end
            op_ori: begin
                ctrl.alu_op = alu_or;
                zero_ext    = 1'b1;
            end
            op_xori: begin
                ctrl.alu_op = alu_xor;
                zero_ext    = 1'b1;
            end
            op_lui: ctrl.alu_op = alu_lui;
            op_lw:  ctrl.mem_read = 1'b1;
            op_sw: begin
                ctrl.mem_write = 1'b1;
                ctrl.reg_write = 1'b0;
            end
            default: legal = 1'b0;
        endcase
        ctrl.alu_src   = (opcode != op_rtype);
        ctrl.shift_src = (opcode == op_rtype) && (funct inside {fn_sll, fn_srl, fn_sra});
        // the all-zero word goes down as a bubble
        if (id_inst == nop_inst) begin
            legal = 1'b0;
        end
    end

    always_comb begin
        id_ex_next.ctrl         = ctrl;
        id_ex_next.rs_data      = rs_data;
        id_ex_next.rt_data      = rt_data;
        id_ex_next.immediate    = zero_ext ? {16'b0, id_inst[15:0]}
                                           : {{16{id_inst[15]}}, id_inst[15:0]};
        id_ex_next.shift_amount = {{(xlen-5){1'b0}}, id_inst[10:6]};
        id_ex_next.rd_num       = (opcode == op_rtype) ? id_inst[15:11] : id_inst[20:16];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            to_ex.valid <= 1'b0;
        end else if (!to_ex.hold) begin
            to_ex.valid <= id_valid & legal;
        end
    end

    always_ff @(posedge clk) begin
        if (!to_ex.hold) begin
            to_ex.payload <= id_ex_next;
        end
    end

endmodule

//--- hdl/regfile.sv
`timescale 1ns/1ns

module regfile import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  reg_num_t        rs_num,
    input  reg_num_t        rt_num,
    output logic [xlen-1:0] rs_data,
    output logic [xlen-1:0] rt_data,
    stage_link.sink         from_mem
);
    logic [xlen-1:0] regs [32];
    logic            wr_en;

    assign from_mem.hold = 1'b0;   // writeback always completes
    assign wr_en = from_mem.valid && from_mem.payload.reg_write
                   && (from_mem.payload.rd_num != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[from_mem.payload.rd_num] <= from_mem.payload.data;
        end
    end

    // write data bypasses to a read of the same register in the same cycle
    assign rs_data = (rs_num == 5'd0) ? '0 :
                     (wr_en && from_mem.payload.rd_num == rs_num) ? from_mem.payload.data :
                     regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 :
                     (wr_en && from_mem.payload.rd_num == rt_num) ? from_mem.payload.data :
                     regs[rt_num];

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    stage_link.sink   from_id,
    stage_link.source to_mem
);
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    ex_mem_t         ex_mem_next;

    assign from_id.hold = to_mem.hold;

    assign op_a = from_id.payload.ctrl.shift_src ? from_id.payload.shift_amount
                                                 : from_id.payload.rs_data;
    assign op_b = from_id.payload.ctrl.alu_src ? from_id.payload.immediate
                                               : from_id.payload.rt_data;

    always_comb begin
        case (from_id.payload.ctrl.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_nor: result = ~(op_a | op_b);
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sll: result = op_b << op_a[4:0];
            alu_srl: result = op_b >> op_a[4:0];
            alu_sra: result = $unsigned($signed(op_b) >>> op_a[4:0]);
            alu_lui: result = {op_b[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_mem_next.ctrl       = from_id.payload.ctrl;
        ex_mem_next.alu_result = result;
        ex_mem_next.rt_data    = from_id.payload.rt_data;   // store data
        ex_mem_next.rd_num     = from_id.payload.rd_num;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            to_mem.valid <= 1'b0;
        end else if (!to_mem.hold) begin
            to_mem.valid <= from_id.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!to_mem.hold) begin
            to_mem.payload <= ex_mem_next;
        end
    end

    a_alu_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        from_id.valid |-> from_id.payload.ctrl.alu_op inside {alu_add, alu_sub, alu_and,
            alu_or, alu_xor, alu_nor, alu_slt, alu_sll, alu_srl, alu_sra, alu_lui});

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ns

module memory_stage import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    stage_link.sink         from_ex,
    stage_link.source       to_wb,
    output logic            stall,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output logic [xlen-1:0] wb_adr,
    output logic [xlen-1:0] wb_wdata,
    input  logic [xlen-1:0] wb_rdata,
    input  logic            wb_ack
);
    logic            mem_req;
    logic            done;       // ack seen, instruction may leave next edge
    logic [xlen-1:0] load_data;
    mem_wb_t         mem_wb_next;

    assign mem_req = from_ex.valid
                     && (from_ex.payload.ctrl.mem_read || from_ex.payload.ctrl.mem_write);

    // bus cycle opens straight from the ex/mem register
    assign wb_cyc   = mem_req && !done;
    assign wb_stb   = wb_cyc;
    assign wb_we    = wb_cyc && from_ex.payload.ctrl.mem_write;
    assign wb_adr   = from_ex.payload.alu_result;
    assign wb_wdata = from_ex.payload.rt_data;

    // high through the ack cycle
    assign stall        = (mem_req && !done) || to_wb.hold;
    assign from_ex.hold = stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (wb_cyc && wb_ack) begin
            done <= 1'b1;
        end else if (!stall) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_cyc && wb_ack && !wb_we) begin
            load_data <= wb_rdata;
        end
    end

    always_comb begin
        mem_wb_next.reg_write = from_ex.payload.ctrl.reg_write;
        mem_wb_next.rd_num    = from_ex.payload.rd_num;
        mem_wb_next.data      = from_ex.payload.ctrl.mem_read ? load_data
                                                              : from_ex.payload.alu_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            to_wb.valid <= 1'b0;
        end else if (!to_wb.hold) begin
            to_wb.valid <= from_ex.valid && !stall;   // bubble while the access waits
        end
    end

    always_ff @(posedge clk) begin
        if (!to_wb.hold) begin
            to_wb.payload <= mem_wb_next;
        end
    end

    // a waiting strobe keeps cyc, address and direction
    a_stb_steady: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr) && $stable(wb_we));

    a_cyc_drops: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && wb_ack |=> !wb_cyc);

endmodule

//--- hdl/mips_pipeline.sv
`timescale 1ns/1ns

module mips_pipeline import mips_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] inst_addr,
    input  logic [xlen-1:0] inst,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output logic [xlen-1:0] wb_adr,
    output logic [xlen-1:0] wb_wdata,
    input  logic [xlen-1:0] wb_rdata,
    input  logic            wb_ack
);
    logic [xlen-1:0] id_inst;
    logic            id_valid;
    reg_num_t        rs_num;
    reg_num_t        rt_num;
    logic [xlen-1:0] rs_data;
    logic [xlen-1:0] rt_data;
    logic            stall;

    stage_link #(.payload_t(id_ex_t))  id_ex_link ();
    stage_link #(.payload_t(ex_mem_t)) ex_mem_link ();
    stage_link #(.payload_t(mem_wb_t)) mem_wb_link ();

    fetch_stage fetch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .hold      (stall),
        .inst      (inst),
        .inst_addr (inst_addr),
        .id_inst   (id_inst),
        .id_valid  (id_valid)
    );

    decode_stage decode0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_inst  (id_inst),
        .id_valid (id_valid),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .rs_num   (rs_num),
        .rt_num   (rt_num),
        .to_ex    (id_ex_link.source)
    );

    regfile regfile0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs_num   (rs_num),
        .rt_num   (rt_num),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .from_mem (mem_wb_link.sink)
    );

    execute_stage execute0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .from_id (id_ex_link.sink),
        .to_mem  (ex_mem_link.source)
    );

    memory_stage memory0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .from_ex  (ex_mem_link.sink),
        .to_wb    (mem_wb_link.source),
        .stall    (stall),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

endmodule

//--- tb/tb_program.svh
logic [31:0] lcg_state = 32'h3b1c5e22;
logic [31:0] rom [rom_words];
int          prog_len;
logic [31:0] model_mem [data_words];
logic        exp_we [$];
logic [31:0] exp_adr [$];
logic [31:0] exp_dat [$];

function automatic int pick(int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return int'(lcg_state[30:8]) % n;
endfunction

// initial data memory, differs in every address bit
function automatic logic [31:0] fill_word(logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], ~addr[15:0]};
endfunction

function automatic logic [15:0] rand_offset();
    return 16'(data_base + 32'(4 * pick(data_words)));
endfunction

// one instruction, then three nops so no two instructions depend closer than that
function automatic void emit(logic [31:0] word);
    rom[prog_len] = word;
    for (int i = 1; i <= 3; i++) begin
        rom[prog_len + i] = nop_inst;
    end
    prog_len += 4;
endfunction

task automatic build_program(int groups);
    logic [5:0] fn_list [12] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
                                 fn_xor, fn_nor, fn_slt, fn_sll, fn_srl, fn_sra};
    logic [5:0] op_list [7] = '{op_addiu, op_addi, op_andi, op_ori, op_xori, op_slti, op_lui};
    reg_num_t   dst;
    reg_num_t   src_a;
    reg_num_t   src_b;
    logic [5:0] fn;
    logic [5:0] op;
    prog_len = 0;
    for (int g = 0; g < groups; g++) begin
        dst   = 5'(pick(8));   // r0 included on purpose
        src_a = 5'(pick(8));
        src_b = 5'(pick(8));
        case (pick(4))
            0, 1: begin
                fn = fn_list[pick(12)];
                if (fn inside {fn_sll, fn_srl, fn_sra}) begin
                    emit({op_rtype, 5'd0, src_b, dst, 5'(pick(32)), fn});
                end else begin
                    emit({op_rtype, src_a, src_b, dst, 5'd0, fn});
                end
            end
            2: begin
                op = op_list[pick(7)];
                emit({op, (op == op_lui) ? 5'd0 : src_a, dst, 16'(pick(65536))});
            end
            default: begin   // load, modify, store back
                emit({op_lw, 5'd0, dst, rand_offset()});
                emit({op_addiu, dst, dst, 16'(pick(65536))});
            end
        endcase
        emit({op_sw, 5'd0, dst, rand_offset()});
    end
endtask

function automatic void expect_access(logic we, logic [31:0] addr, logic [31:0] data);
    exp_we.push_back(we);
    exp_adr.push_back(addr);
    exp_dat.push_back(data);
endfunction

// sequential instruction-set model over the whole program
task automatic run_model();
    logic [31:0] gpr [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] val;
    logic [4:0]  dest;
    logic        wr;
    for (int i = 0; i < 32; i++) begin
        gpr[i] = '0;
    end
    for (int i = 0; i < data_words; i++) begin
        model_mem[i] = fill_word(data_base + 32'(4 * i));
    end
    for (int pc = 0; pc < prog_len; pc++) begin
        w    = rom[pc];
        a    = gpr[w[25:21]];
        b    = gpr[w[20:16]];
        simm = {{16{w[15]}}, w[15:0]};
        addr = a + simm;
        dest = (w[31:26] == op_rtype) ? w[15:11] : w[20:16];
        wr   = 1'b1;
        val  = '0;
        case (w[31:26])
            op_rtype: begin
                case (w[5:0])
                    fn_add, fn_addu: val = a + b;
                    fn_sub, fn_subu: val = a - b;
                    fn_and:          val = a & b;
                    fn_or:           val = a | b;
                    fn_xor:          val = a ^ b;
                    fn_nor:          val = ~(a | b);
                    fn_slt:          val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sll:          val = b << w[10:6];
                    fn_srl:          val = b >> w[10:6];
                    fn_sra:          val = $signed(b) >>> w[10:6];
                    default:         wr = 1'b0;
                endcase
            end
            op_addiu, op_addi: val = a + simm;
            op_slti:           val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            op_andi:           val = a & {16'h0, w[15:0]};
            op_ori:            val = a | {16'h0, w[15:0]};
            op_xori:           val = a ^ {16'h0, w[15:0]};
            op_lui:            val = {w[15:0], 16'h0};
            op_lw: begin
                val = model_mem[addr[5:2]];
                expect_access(1'b0, addr, val);
            end
            op_sw: begin
                wr = 1'b0;
                model_mem[addr[5:2]] = b;
                expect_access(1'b1, addr, b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dest != 5'd0) begin
            gpr[dest] = val;
        end
    end
endtask

//--- tb/tb_mips_pipeline.sv
`timescale 1ns/1ns

module tb_mips_pipeline import mips_pkg::*; ();
    localparam logic [31:0] data_base    = 32'h100;
    localparam int          data_words   = 16;
    localparam int          rom_words    = 1024;
    localparam int          groups       = 64;
    localparam int          reset_cycles = 8;

    logic            clk;
    logic            rst_n;
    logic [xlen-1:0] inst_addr;
    logic [xlen-1:0] inst;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [xlen-1:0] wb_adr;
    logic [xlen-1:0] wb_wdata;
    logic [xlen-1:0] wb_rdata;
    logic            wb_ack;

    logic [31:0] bus_mem [data_words];
    logic [31:0] rd_word;
    int          n_checks;
    int          errors;
    int          err_mark;
    int          seen;          // bus transactions served so far
    int          wait_cnt;
    int          limit_cycles;
    logic        fetch_live;
    logic [31:0] addr_q;
    logic        cyc_q;

    `include "tb_program.svh"

    mips_pipeline dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_addr (inst_addr),
        .inst      (inst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack)
    );

    assign inst = (inst_addr < 4 * prog_len) ? rom[inst_addr[11:2]] : nop_inst;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic serve_access(output logic [31:0] rdata);
        logic [31:0] data;
        if (wb_adr < data_base || wb_adr >= data_base + 4 * data_words
                || wb_adr[1:0] != 2'b00) begin
            errors++;
            $display("bus access at %h falls outside the data window", wb_adr);
        end
        if (wb_we) begin
            bus_mem[wb_adr[5:2]] = wb_wdata;
            data = wb_wdata;
        end else begin
            data = bus_mem[wb_adr[5:2]];
        end
        rdata = data;
        if (seen >= exp_adr.size()) begin
            errors++;
            $display("bus transaction %0d was not expected by the model", seen);
        end else begin
            check("wb_we", 32'(wb_we), 32'(exp_we[seen]));
            check("wb_adr", wb_adr, exp_adr[seen]);
            if (wb_we) begin
                check("wb_wdata", wb_wdata, exp_dat[seen]);
            end
        end
        seen++;
    endtask

    // wishbone slave that acks after 0 to 3 extra cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt != 0) begin
                wait_cnt--;
            end else begin
                serve_access(rd_word);
                wb_rdata <= rd_word;
                wb_ack   <= 1'b1;
                wait_cnt = pick(4);
            end
        end
    end

    // fetch holds its address exactly while a bus cycle is open
    always @(posedge clk) begin
        if (!rst_n) begin
            check("wb_cyc", 32'(wb_cyc), 32'd0);
            check("wb_stb", 32'(wb_stb), 32'd0);
            check("inst_addr", inst_addr, 32'd0);
        end else if (fetch_live) begin
            check("inst_addr", inst_addr, cyc_q ? addr_q : addr_q + 32'd4);
        end
        fetch_live <= rst_n;
        addr_q     <= inst_addr;
        cyc_q      <= wb_cyc;
    end

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: program not finished after %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        wb_ack     = 1'b0;
        wb_rdata   = '0;
        fetch_live = 1'b0;
        addr_q     = '0;
        cyc_q      = 1'b0;
        n_checks   = 0;
        errors     = 0;
        seen       = 0;
        build_program(groups);
        run_model();
        for (int i = 0; i < data_words; i++) begin
            bus_mem[i] = fill_word(data_base + 32'(4 * i));
        end
        wait_cnt     = pick(4);
        limit_cycles = 2 * (prog_len + 5 * exp_adr.size()) + reset_cycles;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        $display("reset test: %0d errors", errors);
        err_mark = errors;

        while (!(seen == exp_adr.size() && inst_addr >= 4 * prog_len && !wb_cyc)) begin
            @(negedge clk);
        end
        $display("program run test: %0d bus transactions, %0d errors", seen,
                 errors - err_mark);
        err_mark = errors;

        for (int i = 0; i < data_words; i++) begin
            check($sformatf("data word %h", data_base + 32'(4 * i)), bus_mem[i], model_mem[i]);
        end
        $display("memory contents test: %0d errors", errors - err_mark);

        $display("%0d checks, %0d errors", n_checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- mips_pipeline.f
+incdir+tb
hdl/mips_pkg.sv
hdl/stage_link.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/regfile.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipeline.sv
tb/tb_mips_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_pipeline \
    -f mips_pipeline.f -o sim_tb &&
sim_out="$(./obj_dir/sim_tb)" &&
echo "$sim_out" &&
grep -q "Done: no errors" <<< "$sim_out" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
